// ==== regx_pkg.sv ====
// Shared widths, opcodes, command and write-back structs, and the APB map for the register unit
package regx_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int REG_COUNT  = 32;
    localparam int ADDR_BITS  = 5;
    localparam int PADDR_BITS = 12;
    localparam int COUNT_BITS = 16;

    typedef logic [DATA_WIDTH-1:0] regx_data_t;
    typedef logic [ADDR_BITS-1:0]  regx_addr_t;
    typedef logic [PADDR_BITS-1:0] regx_paddr_t;
    typedef logic [COUNT_BITS-1:0] regx_count_t;

    typedef enum logic [2:0] {
        OP_LOAD = 3'd0,
        OP_SUB  = 3'd1,
        OP_ADD  = 3'd2,
        OP_AND  = 3'd3,
        OP_XOR  = 3'd4
    } regx_op_t;

    typedef struct packed {
        regx_op_t   op;
        regx_addr_t rd;
        regx_addr_t rs1;
        regx_addr_t rs2;
        regx_data_t imm;
    } regx_cmd_t;

    typedef struct packed {
        logic       en;
        regx_addr_t addr;
        regx_data_t data;
    } regx_wb_t;

    // APB byte addresses
    localparam regx_paddr_t ADDR_CMD      = 12'h000;
    localparam regx_paddr_t ADDR_DATA     = 12'h004;
    localparam regx_paddr_t ADDR_STATUS   = 12'h008;
    localparam regx_paddr_t ADDR_REG_BASE = 12'h100;

    // Field positions in a CMD write
    localparam int CMD_OP_LSB  = 0;
    localparam int CMD_RD_LSB  = 8;
    localparam int CMD_RS1_LSB = 16;
    localparam int CMD_RS2_LSB = 24;

    // Status word bits
    localparam int STAT_BUSY_BIT   = 0;
    localparam int STAT_BORROW_BIT = 1;
    localparam int STAT_COUNT_LSB  = 16;

endpackage

// ==== regx_regfile.sv ====
// Register file with one write port and three forwarding read ports, r0 fixed at zero
module regx_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_COUNT  = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  regx_pkg::regx_wb_t   wb,
    input  regx_pkg::regx_addr_t rd_addr1,
    input  regx_pkg::regx_addr_t rd_addr2,
    input  regx_pkg::regx_addr_t rd_addr3,
    output regx_pkg::regx_data_t rd_data1,
    output regx_pkg::regx_data_t rd_data2,
    output regx_pkg::regx_data_t rd_data3
);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    logic wr_ok;

    // r0 and indices past the array never take a write
    assign wr_ok = wb.en && (wb.addr != '0) && (int'(wb.addr) < REG_COUNT);

    // Same-cycle write data wins over the stored value, r0 keeps its reset value
    function automatic regx_pkg::regx_data_t read_port(input regx_pkg::regx_addr_t addr);
        regx_pkg::regx_data_t val;
        if (int'(addr) >= REG_COUNT) begin
            val = '0;
        end else if (wr_ok && (wb.addr == addr)) begin
            val = wb.data;
        end else begin
            val = regx_pkg::regx_data_t'(regs[addr]);
        end
        return val;
    endfunction

    always_comb begin
        rd_data1 = read_port(rd_addr1);
    end

    always_comb begin
        rd_data2 = read_port(rd_addr2);
    end

    // Port 3 serves the APB debug window
    always_comb begin
        rd_data3 = read_port(rd_addr3);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb.addr] <= wb.data[DATA_WIDTH-1:0];
        end
    end

    // r0 stays zero on every port, also while a write to it is in flight
    property p_r0_zero;
        @(posedge clk) disable iff (rst)
            ((rd_addr1 == '0) |-> (rd_data1 == '0)) and
            ((rd_addr2 == '0) |-> (rd_data2 == '0)) and
            ((rd_addr3 == '0) |-> (rd_data3 == '0));
    endproperty

    a_r0_zero: assert property (p_r0_zero)
        else $error("register 0 read back nonzero");

endmodule

// ==== regx_alu.sv ====
// Combinational execute unit with ripple-borrow subtract, add and bitwise operations
module regx_alu #(
    parameter int DATA_WIDTH = 32
) (
    input  regx_pkg::regx_op_t   op,
    input  regx_pkg::regx_data_t a,
    input  regx_pkg::regx_data_t b,
    input  regx_pkg::regx_data_t imm,
    output regx_pkg::regx_data_t result,
    output logic                 borrow
);

    logic [DATA_WIDTH-1:0] diff;
    logic [DATA_WIDTH:0]   bchain;

    assign bchain[0] = 1'b0;

    // One full subtractor per bit, borrow ripples upward
    genvar j;
    generate
        for (j = 0; j < DATA_WIDTH; j++) begin : g_sub
            assign diff[j] = a[j] ^ b[j] ^ bchain[j];
            assign bchain[j+1] = (~a[j] & b[j]) |
                                 (~a[j] & bchain[j]) |
                                 (b[j] & bchain[j]);
        end
    endgenerate

    // Set exactly when b > a unsigned
    assign borrow = bchain[DATA_WIDTH];

    always_comb begin
        case (op)
            regx_pkg::OP_LOAD: begin
                result = imm;
            end
            regx_pkg::OP_SUB: begin
                result = regx_pkg::regx_data_t'(diff);
            end
            regx_pkg::OP_ADD: begin
                result = a + b;
            end
            regx_pkg::OP_AND: begin
                result = a & b;
            end
            regx_pkg::OP_XOR: begin
                result = a ^ b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== regx_pipe.sv ====
// Two-stage command pipeline feeding the ALU and writing results back, with status tracking
module regx_pipe #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_COUNT  = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  regx_pkg::regx_cmd_t   cmd,
    input  logic                  cmd_valid,
    input  regx_pkg::regx_data_t  rs1_data,
    input  regx_pkg::regx_data_t  rs2_data,
    input  regx_pkg::regx_data_t  alu_result,
    input  logic                  alu_borrow,
    output regx_pkg::regx_addr_t  rs1_addr,
    output regx_pkg::regx_addr_t  rs2_addr,
    output regx_pkg::regx_op_t    alu_op,
    output regx_pkg::regx_data_t  alu_a,
    output regx_pkg::regx_data_t  alu_b,
    output regx_pkg::regx_data_t  alu_imm,
    output regx_pkg::regx_wb_t    wb,
    output logic                  busy,
    output logic                  borrow,
    output regx_pkg::regx_count_t done_count
);

    // Data path and index space must fit the shared types
    generate
        if (DATA_WIDTH > $bits(regx_pkg::regx_data_t)) begin : g_bad_width
            $error("DATA_WIDTH wider than the register value type");
        end
        if (REG_COUNT > (1 << regx_pkg::ADDR_BITS)) begin : g_bad_count
            $error("REG_COUNT does not fit the register index");
        end
    endgenerate

    logic                s1_valid;
    regx_pkg::regx_cmd_t s1_cmd;
    logic                wb_is_sub;
    logic                wb_borrow;

    // Stage 1 holds the accepted command for one cycle
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            s1_cmd <= cmd;
        end
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cmd_valid;
        end
    end

    // Operand fetch, forwarded by the register file when wb targets a source
    assign rs1_addr = s1_cmd.rs1;
    assign rs2_addr = s1_cmd.rs2;
    assign alu_op   = s1_cmd.op;
    assign alu_a    = rs1_data;
    assign alu_b    = rs2_data;
    assign alu_imm  = s1_cmd.imm;

    // Stage 2 is the write-back register
    always_ff @(posedge clk) begin
        wb.addr   <= s1_cmd.rd;
        wb.data   <= alu_result;
        wb_is_sub <= (s1_cmd.op == regx_pkg::OP_SUB);
        wb_borrow <= alu_borrow;
        if (rst) begin
            wb.en <= 1'b0;
        end else begin
            wb.en <= s1_valid;
        end
    end

    assign busy = s1_valid || wb.en;

    // Borrow holds until the next SUB retires
    always_ff @(posedge clk) begin
        if (rst) begin
            borrow     <= 1'b0;
            done_count <= '0;
        end else if (wb.en) begin
            done_count <= done_count + 1'b1;
            if (wb_is_sub) begin
                borrow <= wb_borrow;
            end
        end
    end

    // Every accepted command reaches write-back two edges later
    property p_cmd_retires;
        @(posedge clk) disable iff (rst)
            cmd_valid |-> ##2 wb.en;
    endproperty

    a_cmd_retires: assert property (p_cmd_retires)
        else $error("accepted command did not reach write-back");

    // APB side must only name existing registers
    property p_cmd_in_range;
        @(posedge clk) disable iff (rst)
            cmd_valid |-> (int'(cmd.rd) < REG_COUNT) && (int'(cmd.rs1) < REG_COUNT)
                          && (int'(cmd.rs2) < REG_COUNT);
    endproperty

    a_cmd_in_range: assert property (p_cmd_in_range)
        else $error("command names a register past REG_COUNT");

endmodule

// ==== regx_apb_if.sv ====
// APB slave decoding the command, data, status and register window, feeding the pipeline
module regx_apb_if #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  regx_pkg::regx_paddr_t paddr,
    input  regx_pkg::regx_data_t  pwdata,
    output regx_pkg::regx_data_t  prdata,
    output logic                  pready,
    output logic                  pslverr,
    output regx_pkg::regx_cmd_t   cmd,
    output logic                  cmd_valid,
    output regx_pkg::regx_addr_t  dbg_addr,
    input  regx_pkg::regx_data_t  dbg_data,
    input  logic                  busy,
    input  logic                  borrow,
    input  regx_pkg::regx_count_t done_count
);

    logic                  access;
    logic                  is_cmd;
    logic                  is_data;
    logic                  is_status;
    logic                  is_reg;
    logic                  mapped;
    regx_pkg::regx_paddr_t reg_off;
    regx_pkg::regx_data_t  status;
    logic [DATA_WIDTH-1:0] data_reg;

    assign access = psel && penable;

    // Address decode
    assign reg_off   = paddr - regx_pkg::ADDR_REG_BASE;
    assign is_cmd    = (paddr == regx_pkg::ADDR_CMD);
    assign is_data   = (paddr == regx_pkg::ADDR_DATA);
    assign is_status = (paddr == regx_pkg::ADDR_STATUS);
    assign is_reg    = (paddr >= regx_pkg::ADDR_REG_BASE) && (paddr[1:0] == 2'b00)
                       && (int'(reg_off[regx_pkg::PADDR_BITS-1:2]) < regx_pkg::REG_COUNT);
    assign mapped    = is_cmd || is_data || is_status || is_reg;

    assign dbg_addr = reg_off[2 +: regx_pkg::ADDR_BITS];

    // No wait states
    assign pready = 1'b1;

    // STATUS and the register window are read only
    assign pslverr = access && (!mapped || (pwrite && (is_status || is_reg)));

    // DATA register holds the next LOAD value
    always_ff @(posedge clk) begin
        if (rst) begin
            data_reg <= '0;
        end else if (access && pwrite && is_data) begin
            data_reg <= pwdata[DATA_WIDTH-1:0];
        end
    end

    // Command fields from the write data, imm from DATA
    always_comb begin
        cmd.op  = regx_pkg::regx_op_t'(pwdata[regx_pkg::CMD_OP_LSB +: 3]);
        cmd.rd  = pwdata[regx_pkg::CMD_RD_LSB +: regx_pkg::ADDR_BITS];
        cmd.rs1 = pwdata[regx_pkg::CMD_RS1_LSB +: regx_pkg::ADDR_BITS];
        cmd.rs2 = pwdata[regx_pkg::CMD_RS2_LSB +: regx_pkg::ADDR_BITS];
        cmd.imm = regx_pkg::regx_data_t'(data_reg);
    end

    assign cmd_valid = access && pwrite && is_cmd;

    always_comb begin
        status = '0;
        status[regx_pkg::STAT_BUSY_BIT]   = busy;
        status[regx_pkg::STAT_BORROW_BIT] = borrow;
        status[regx_pkg::STAT_COUNT_LSB +: regx_pkg::COUNT_BITS] = done_count;
    end

    // Read mux, CMD reads back as zero
    always_comb begin
        if (is_data) begin
            prdata = regx_pkg::regx_data_t'(data_reg);
        end else if (is_status) begin
            prdata = status;
        end else if (is_reg) begin
            prdata = dbg_data;
        end else begin
            prdata = '0;
        end
    end

    // Access phase always follows a setup phase of the same transfer
    property p_apb_phases;
        @(posedge clk) disable iff (rst)
            penable |-> psel && $past(psel && !penable);
    endproperty

    a_apb_phases: assert property (p_apb_phases)
        else $error("penable without a preceding setup phase");

endmodule

// ==== regx_top.sv ====
// Top level of the APB register execution unit, wiring slave, pipeline, ALU and register file
module regx_top #(
    parameter int DATA_WIDTH = regx_pkg::DATA_WIDTH,
    parameter int REG_COUNT  = regx_pkg::REG_COUNT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  regx_pkg::regx_paddr_t paddr,
    input  regx_pkg::regx_data_t  pwdata,
    output regx_pkg::regx_data_t  prdata,
    output logic                  pready,
    output logic                  pslverr
);

    regx_pkg::regx_cmd_t   cmd;
    logic                  cmd_valid;
    regx_pkg::regx_addr_t  dbg_addr;
    regx_pkg::regx_data_t  dbg_data;
    logic                  busy;
    logic                  borrow;
    regx_pkg::regx_count_t done_count;
    regx_pkg::regx_addr_t  rs1_addr;
    regx_pkg::regx_addr_t  rs2_addr;
    regx_pkg::regx_data_t  rs1_data;
    regx_pkg::regx_data_t  rs2_data;
    regx_pkg::regx_op_t    alu_op;
    regx_pkg::regx_data_t  alu_a;
    regx_pkg::regx_data_t  alu_b;
    regx_pkg::regx_data_t  alu_imm;
    regx_pkg::regx_data_t  alu_result;
    logic                  alu_borrow;
    regx_pkg::regx_wb_t    wb;

    regx_apb_if #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_apb_if (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data),
        .busy       (busy),
        .borrow     (borrow),
        .done_count (done_count)
    );

    regx_pipe #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_COUNT  (REG_COUNT)
    ) i_pipe (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .alu_borrow (alu_borrow),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_imm    (alu_imm),
        .wb         (wb),
        .busy       (busy),
        .borrow     (borrow),
        .done_count (done_count)
    );

    regx_alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .imm    (alu_imm),
        .result (alu_result),
        .borrow (alu_borrow)
    );

    // Port 3 is the debug read path for the APB register window
    regx_regfile #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_COUNT  (REG_COUNT)
    ) i_regfile (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rd_addr1 (rs1_addr),
        .rd_addr2 (rs2_addr),
        .rd_addr3 (dbg_addr),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data),
        .rd_data3 (dbg_data)
    );

endmodule

// ==== tb_regx.sv ====
// Testbench for the APB register execution unit, replays regx_stim.txt as APB transfers
module tb_regx;

    localparam int CLK_HALF    = 50;
    localparam int STIM_WORDS  = 1024;
    localparam int RESET_TICKS = 5;

    // Kinds in the first column of the stimulus file
    localparam logic [31:0] KIND_WRITE     = 32'h0;
    localparam logic [31:0] KIND_READ      = 32'h1;
    localparam logic [31:0] KIND_WRITE_ERR = 32'h2;
    localparam logic [31:0] KIND_READ_ERR  = 32'h3;
    localparam logic [31:0] KIND_TEST_END  = 32'h8;
    localparam logic [31:0] KIND_STOP      = 32'hf;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    regx_pkg::regx_paddr_t paddr;
    regx_pkg::regx_data_t  pwdata;
    regx_pkg::regx_data_t  prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0] stim [STIM_WORDS];

    int cycles       = 0;
    int cycle_limit  = 0;
    int error_count  = 0;
    int test_errors  = 0;
    int tests_done   = 0;
    int tests_failed = 0;

    regx_top i_regx_top (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
    end

    always #CLK_HALF clk = ~clk;

    // Run limit, set once the stimulus length is known
    always @(posedge clk) begin
        cycles++;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            note_error();
        end
    endtask

    // One APB transfer, setup and access phases start on falling edges
    task automatic apb_transfer(input logic write, input regx_pkg::regx_paddr_t addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err, output logic ready);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // Mid access phase, well clear of both edges
        #(CLK_HALF / 2);
        rdata = prdata;
        err   = pslverr;
        ready = pready;
        @(posedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_line(input int line);
        logic [31:0]           kind;
        regx_pkg::regx_paddr_t addr;
        logic [31:0]           wdata;
        logic [31:0]           expected;
        logic [31:0]           rdata;
        logic                  err;
        logic                  ready;
        logic                  want_err;
        kind     = stim[line * 4];
        addr     = stim[line * 4 + 1][11:0];
        wdata    = stim[line * 4 + 2];
        expected = stim[line * 4 + 3];
        if (kind == KIND_TEST_END) begin
            tests_done++;
            if (test_errors != 0) begin
                tests_failed++;
            end
            $display("Test %0d finished: %s with %0d errors", addr,
                     (test_errors == 0) ? "ok" : "bad", test_errors);
            test_errors = 0;
        end else if (kind inside {KIND_WRITE, KIND_READ, KIND_WRITE_ERR, KIND_READ_ERR}) begin
            want_err = (kind == KIND_WRITE_ERR) || (kind == KIND_READ_ERR);
            apb_transfer((kind == KIND_WRITE) || (kind == KIND_WRITE_ERR), addr, wdata,
                         rdata, err, ready);
            check_value("pready", 32'h1, {31'h0, ready});
            if (want_err && (err !== 1'b1)) begin
                $display("Missing pslverr at time %0t for address %h", $time, addr);
                note_error();
            end else if (!want_err && (err !== 1'b0)) begin
                $display("Unexpected pslverr at time %0t for address %h", $time, addr);
                note_error();
            end
            if (kind == KIND_READ) begin
                check_value($sformatf("prdata(%h)", addr), expected, rdata);
            end
        end else begin
            $display("Stimulus line %0d has an unknown kind %h", line, kind);
            note_error();
        end
    endtask

    initial begin
        int n_lines;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        $readmemh("regx_stim.txt", stim);
        n_lines = 0;
        while ((n_lines * 4 < STIM_WORDS) && (stim[n_lines * 4] !== KIND_STOP)) begin
            n_lines++;
        end
        if (n_lines * 4 >= STIM_WORDS) begin
            $display("Stimulus file missing or without its end marker");
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycle_limit = 4 * n_lines + 20;
            repeat (RESET_TICKS) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                run_line(i);
            end
            bus_idle();
            repeat (2) @(posedge clk);
            $display("Tests run %0d, tests failed %0d, errors %0d",
                     tests_done, tests_failed, error_count);
            if ((error_count == 0) && (tests_failed == 0)) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== regx_stim.txt ====
// kind addr wdata expected, kind 0 write, 1 read, 2 write with pslverr, 3 read with pslverr
// kind 8 ends test number addr, kind f ends the file; CMD = rs2<<24 | rs1<<16 | rd<<8 | op
00000001 00000100 00000000 00000000
00000001 00000104 00000000 00000000
00000001 0000017c 00000000 00000000
00000001 00000008 00000000 00000000
00000001 00000004 00000000 00000000
00000008 00000001 00000000 00000000
00000000 00000004 00000064 00000000
00000000 00000000 00000100 00000000
00000000 00000004 0000001e 00000000
00000000 00000000 00000200 00000000
00000000 00000004 00000005 00000000
00000000 00000000 00000300 00000000
00000000 00000004 00000009 00000000
00000000 00000000 00000400 00000000
00000000 00000004 deadbeef 00000000
00000000 00000000 00000000 00000000
00000001 00000100 00000000 00000000
00000001 00000104 00000000 00000064
00000001 00000108 00000000 0000001e
00000001 0000010c 00000000 00000005
00000001 00000110 00000000 00000009
00000001 00000004 00000000 deadbeef
00000008 00000002 00000000 00000000
00000000 00000000 02010501 00000000
00000001 00000114 00000000 00000046
00000001 00000008 00000000 00060000
00000000 00000000 04030601 00000000
00000001 00000118 00000000 fffffffc
00000001 00000008 00000000 00070002
00000008 00000003 00000000 00000000
00000000 00000004 f0f0a5a5 00000000
00000000 00000000 00000700 00000000
00000000 00000004 0ff0ffff 00000000
00000000 00000000 00000800 00000000
00000000 00000000 08070902 00000000
00000000 00000000 08070a03 00000000
00000000 00000000 08070b04 00000000
00000001 00000124 00000000 00e1a5a4
00000001 00000128 00000000 00f0a5a5
00000001 0000012c 00000000 ff005a5a
00000001 00000008 00000000 000c0002
00000008 00000004 00000000 00000000
00000000 00000000 02010c02 00000000
00000000 00000000 030c0d01 00000000
00000000 00000000 0c0d0e04 00000000
00000000 00000000 0c0c0c02 00000000
00000001 00000130 00000000 00000104
00000001 00000134 00000000 0000007d
00000001 00000138 00000000 000000ff
00000001 00000008 00000000 00100000
00000008 00000005 00000000 00000000
00000003 00000200 00000000 00000000
00000002 0000000c 12345678 00000000
00000002 00000008 00000001 00000000
00000002 00000104 00000001 00000000
00000001 00000104 00000000 00000064
00000001 00000008 00000000 00100000
00000008 00000006 00000000 00000000
0000000f 00000000 00000000 00000000

// ==== compile.f ====
regx_pkg.sv
regx_regfile.sv
regx_alu.sv
regx_pipe.sv
regx_apb_if.sv
regx_top.sv
tb_regx.sv

// ==== Bender.yml ====
package:
  name: regx

sources:
  - regx_pkg.sv
  - regx_regfile.sv
  - regx_alu.sv
  - regx_pipe.sv
  - regx_apb_if.sv
  - regx_top.sv
  - target: simulation
    files:
      - tb_regx.sv
